/* Bender.yml */
package:
  name: mem_pg_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_cfg_pkg.sv
      - verilog/pwr_pkg.sv
      - verilog/mem_reset_sync.sv
      - verilog/rf_array_8x177.sv
      - verilog/rf_pg_8x177.sv
      - verilog/pwr_gate_ctrl.sv
      - verilog/mem_access_guard.sv
      - verilog/mem_pg_subsys.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/mem_pg_subsys_sva.sv
      - tb/mem_pg_subsys_tb.sv

/* src.f */
+incdir+verilog
verilog/mem_cfg_pkg.sv
verilog/pwr_pkg.sv
verilog/mem_reset_sync.sv
verilog/rf_array_8x177.sv
verilog/rf_pg_8x177.sv
verilog/pwr_gate_ctrl.sv
verilog/mem_access_guard.sv
verilog/mem_pg_subsys.sv
tb/mem_pg_subsys_sva.sv
tb/mem_pg_subsys_tb.sv

/* tb/mem_pg_subsys_sva.sv */
// Assertions for the power-gated register file subsystem
// Bound into the power sequencer and into the access guard
// Unused inputs of each bound copy are tied so their properties hold trivially

`timescale 1ns/1ns
`default_nettype none

module mem_pg_subsys_sva (
     input  logic clk
    ,input  logic arst_n
    ,input  logic isol_en
    ,input  logic enable_b
    ,input  logic pwr_on
    ,input  logic mem_we
    ,input  logic mem_re
    ,input  logic rd_valid
);

    // --------------------
    // Power sequencing

    // The switch may only be open while the outputs are clamped
    a_isol_when_off: assert property (@(posedge clk) disable iff (!arst_n)
        enable_b |-> isol_en)
        else $error("power enable deasserted without isolation");

    // --------------------
    // Access gating

    // Nothing reaches the array unless it is reported powered
    a_no_access_off: assert property (@(posedge clk) disable iff (!arst_n)
        !pwr_on |-> (!mem_we && !mem_re))
        else $error("array access passed while power is off");

    // Read valid is the accepted read delayed by one cycle
    a_valid_after_read: assert property (@(posedge clk) disable iff (!arst_n)
        mem_re |=> rd_valid)
        else $error("accepted read without read valid on the next cycle");

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !mem_re |=> !rd_valid)
        else $error("read valid without an accepted read");

endmodule

bind pwr_gate_ctrl mem_pg_subsys_sva u_ctrl_sva (
     .clk      (rclk)
    ,.arst_n   (arst_n)
    ,.isol_en  (pgcb_isol_en)
    ,.enable_b (pwr_enable_b_in)
    ,.pwr_on   (pwr_on)
    ,.mem_we   (1'b0)
    ,.mem_re   (1'b0)
    ,.rd_valid (1'b0)
);

bind mem_access_guard mem_pg_subsys_sva u_guard_sva (
     .clk      (rclk)
    ,.arst_n   (arst_n)
    ,.isol_en  (1'b1)
    ,.enable_b (1'b0)
    ,.pwr_on   (pwr_on)
    ,.mem_we   (mem_we)
    ,.mem_re   (mem_re)
    ,.rd_valid (rd_valid)
);

`default_nettype wire

/* tb/mem_pg_subsys_tb.sv */
// Testbench for the power-gated register file subsystem
// Runs a table of writes, reads and power commands through the DUT,
// checks read data against a model of the entries and checks the
// power and error flags after each sleep, wake and rejected access

`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module mem_pg_subsys_tb;

    import mem_cfg_pkg::*;
    import pwr_pkg::*;

    // Longest wait for any response, in clock cycles
    localparam int WAIT_LIMIT = 64;

    // Row kinds, RDB keeps the next read on the following cycle and
    // WAKE_GO starts a wake without waiting for it to finish
    typedef enum int {OP_WR, OP_WRRD, OP_RD, OP_RDB, OP_SLEEP, OP_WAKE, OP_WAKE_GO} op_e;

    logic     wclk;
    logic     rclk;
    logic     arst_n;
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
    logic     re;
    rf_addr_t raddr;
    pwr_cmd_e pwr_cmd;
    logic     fscan_rstbypen;
    logic     fscan_byprst_b;
    rf_data_t rdata;
    logic     rd_valid;
    logic     access_err;
    logic     pwr_on;
    logic     pwr_busy;

    // --------------------
    // Stimulus table

    op_e      tbl_op[$];
    rf_addr_t tbl_addr[$];
    rf_data_t tbl_data[$];
    rf_data_t tbl_exp[$];
    logic     tbl_err[$];
    string    tbl_name[$];
    logic     row_fail[$];

    // Rows whose read data has not come back yet, oldest first
    int       pending[$];
    rf_data_t model[`RF_DEPTH];
    int       pass_rows;
    int       fail_rows;
    logic     aborted;

    mem_pg_subsys uut (
         .wclk           (wclk)
        ,.rclk           (rclk)
        ,.arst_n         (arst_n)
        ,.we             (we)
        ,.waddr          (waddr)
        ,.wdata          (wdata)
        ,.re             (re)
        ,.raddr          (raddr)
        ,.pwr_cmd        (pwr_cmd)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rdata          (rdata)
        ,.rd_valid       (rd_valid)
        ,.access_err     (access_err)
        ,.pwr_on         (pwr_on)
        ,.pwr_busy       (pwr_busy)
    );

    // Both clocks share one phase
    always begin
        #4;
        wclk = ~wclk;
        rclk = ~rclk;
    end

    function automatic rf_data_t rand_word();
        logic [191:0] bits;
        bits = {$urandom(), $urandom(), $urandom(), $urandom(), $urandom(), $urandom()};
        return bits[`RF_DATA_W-1:0];
    endfunction

    task automatic add_row(input op_e op, input int addr, input rf_data_t data,
                           input rf_data_t exp, input logic err, input string name);
        tbl_op.push_back(op);
        tbl_addr.push_back(rf_addr_t'(addr));
        tbl_data.push_back(data);
        tbl_exp.push_back(exp);
        tbl_err.push_back(err);
        tbl_name.push_back(name);
        row_fail.push_back(1'b0);
    endtask

    // Reads every entry on consecutive cycles, expecting the model contents
    task automatic add_burst(input string prefix);
        for (int a = 0; a < `RF_DEPTH; a++) begin
            if (a < `RF_DEPTH - 1) begin
                add_row(OP_RDB, a, '0, model[a], 1'b0, $sformatf("%s_%0d", prefix, a));
            end else begin
                add_row(OP_RD, a, '0, model[a], 1'b0, $sformatf("%s_%0d", prefix, a));
            end
        end
    endtask

    task automatic build_table();
        rf_data_t word;
        for (int a = 0; a < `RF_DEPTH; a++) begin
            word     = rand_word();
            model[a] = word;
            add_row(OP_WR, a, word, word, 1'b0, $sformatf("write_%0d", a));
        end
        for (int a = 0; a < `RF_DEPTH; a++) begin
            add_row(OP_RD, a, '0, model[a], 1'b0, $sformatf("read_%0d", a));
        end
        // Overwrite an entry and read it on the very next cycle
        word     = rand_word();
        model[5] = word;
        add_row(OP_WRRD, 5, word, word, 1'b0, "write_then_read_5");
        add_burst("burst");
        // Powering down loses every entry, accesses while off are rejected
        add_row(OP_SLEEP, 0, '0, '0, 1'b0, "sleep");
        for (int a = 0; a < `RF_DEPTH; a++) begin
            model[a] = '0;
        end
        add_row(OP_WR, 2, rand_word(), '0, 1'b1, "write_while_off");
        add_row(OP_RD, 3, '0, '0, 1'b1, "read_while_off");
        add_row(OP_WAKE, 0, '0, rf_data_t'(1), 1'b0, "wake");
        add_burst("after_wake");
        for (int a = 0; a < 4; a++) begin
            word     = rand_word();
            model[a] = word;
            add_row(OP_WRRD, a, word, word, 1'b0, $sformatf("rewrite_%0d", a));
        end
        // A sleep request that lands while waking is still busy has no effect
        add_row(OP_SLEEP, 0, '0, '0, 1'b0, "sleep_again");
        add_row(OP_WAKE_GO, 0, '0, rf_data_t'(1), 1'b0, "wake_no_wait");
        add_row(OP_SLEEP, 0, '0, rf_data_t'(1), 1'b0, "sleep_while_waking");
        add_row(OP_RD, 2, '0, '0, 1'b0, "read_after_restart");
    endtask

    // --------------------
    // Checking and reporting

    task automatic check_value(input int row, input string what,
                               input rf_data_t expected, input rf_data_t actual);
        if (actual !== expected) begin
            $display("mismatch %s %s expected %h actual %h",
                     tbl_name[row], what, expected, actual);
            row_fail[row] = 1'b1;
        end
    endtask

    task automatic report_row(input int row);
        if (row_fail[row]) begin
            fail_rows++;
            $display("test %0d %s FAIL", row, tbl_name[row]);
        end else begin
            pass_rows++;
            $display("test %0d %s ok", row, tbl_name[row]);
        end
    endtask

    // Matches returned data against the oldest read in flight
    task automatic collect_read(input int row);
        int idx;
        if (rd_valid) begin
            if (pending.size() == 0) begin
                $display("read valid during %s with no read in flight", tbl_name[row]);
                row_fail[row] = 1'b1;
            end else begin
                idx = pending.pop_front();
                check_value(idx, "rdata", tbl_exp[idx], rdata);
                report_row(idx);
            end
        end
    endtask

    // Stops issuing reads and waits for every outstanding one to return
    task automatic drain_reads(input int row);
        int cnt;
        int idx;
        cnt = 0;
        @(posedge wclk);
        re <= 1'b0;
        while (pending.size() != 0 && !aborted) begin
            @(negedge wclk);
            collect_read(row);
            cnt++;
            if (pending.size() != 0 && cnt >= WAIT_LIMIT) begin
                $display("timeout in %s, read data never came back", tbl_name[row]);
                aborted = 1'b1;
                while (pending.size() != 0) begin
                    idx           = pending.pop_front();
                    row_fail[idx] = 1'b1;
                    report_row(idx);
                end
            end
        end
    endtask

    // Waits for pwr_on to leave the level it had when the command was given
    // The sequencer then has to come to rest in ON or OFF before pwr_on is judged
    task automatic wait_power(input int row, input logic start_on);
        int cnt;
        cnt = 0;
        while (pwr_on === start_on && !aborted) begin
            @(negedge wclk);
            cnt++;
            if (pwr_on === start_on && cnt >= WAIT_LIMIT) begin
                $display("timeout in %s, power state did not change", tbl_name[row]);
                row_fail[row] = 1'b1;
                aborted       = 1'b1;
            end
        end
        cnt = 0;
        while (pwr_busy !== 1'b0 && !aborted) begin
            @(negedge wclk);
            cnt++;
            if (pwr_busy !== 1'b0 && cnt >= WAIT_LIMIT) begin
                $display("timeout in %s, power sequence never finished", tbl_name[row]);
                row_fail[row] = 1'b1;
                aborted       = 1'b1;
            end
        end
    endtask

    task automatic run_row(input int i);
        logic start_on;
        case (tbl_op[i])
            OP_WR, OP_WRRD: begin
                @(posedge wclk);
                we    <= 1'b1;
                waddr <= tbl_addr[i];
                wdata <= tbl_data[i];
                @(posedge wclk);
                we <= 1'b0;
                if (tbl_op[i] == OP_WRRD) begin
                    re    <= 1'b1;
                    raddr <= tbl_addr[i];
                    pending.push_back(i);
                end
                @(negedge wclk);
                check_value(i, "access_err", rf_data_t'(tbl_err[i]), rf_data_t'(access_err));
                if (tbl_op[i] == OP_WRRD) begin
                    drain_reads(i);
                end else begin
                    report_row(i);
                end
            end
            OP_RD, OP_RDB: begin
                @(posedge wclk);
                re    <= 1'b1;
                raddr <= tbl_addr[i];
                if (tbl_err[i]) begin
                    @(posedge wclk);
                    re <= 1'b0;
                    @(negedge wclk);
                    check_value(i, "access_err", rf_data_t'(1), rf_data_t'(access_err));
                    check_value(i, "rd_valid", '0, rf_data_t'(rd_valid));
                    report_row(i);
                end else begin
                    pending.push_back(i);
                    @(negedge wclk);
                    collect_read(i);
                    if (tbl_op[i] == OP_RD) begin
                        drain_reads(i);
                    end
                end
            end
            default: begin
                start_on = pwr_on;
                @(posedge wclk);
                if (tbl_op[i] == OP_SLEEP) begin
                    pwr_cmd <= PWR_CMD_SLEEP;
                end else begin
                    pwr_cmd <= PWR_CMD_WAKE;
                end
                @(posedge wclk);
                pwr_cmd <= PWR_CMD_NONE;
                if (tbl_op[i] == OP_WAKE_GO) begin
                    @(negedge wclk);
                    check_value(i, "pwr_busy", tbl_exp[i], rf_data_t'(pwr_busy));
                end else begin
                    wait_power(i, start_on);
                    check_value(i, "pwr_on", tbl_exp[i], rf_data_t'(pwr_on));
                    // Writes are accepted only once the write domain sees the new state
                    repeat (4) @(posedge wclk);
                end
                report_row(i);
            end
        endcase
    endtask

    // --------------------
    // Main sequence

    initial begin
        wclk           = 1'b0;
        rclk           = 1'b0;
        arst_n         = 1'b0;
        we             = 1'b0;
        waddr          = '0;
        wdata          = '0;
        re             = 1'b0;
        raddr          = '0;
        pwr_cmd        = PWR_CMD_NONE;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        pass_rows      = 0;
        fail_rows      = 0;
        aborted        = 1'b0;
        void'($urandom(40836));
        build_table();
        repeat (3) @(posedge wclk);
        arst_n <= 1'b1;
        // Leave time for the IP reset to leave its synchronizer
        repeat (4) @(posedge wclk);
        for (int i = 0; i < tbl_op.size() && !aborted; i++) begin
            run_row(i);
        end
        $display("tests passed %0d failed %0d", pass_rows, fail_rows);
        if (fail_rows == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mem_access_guard.sv */
// Access guard in front of the power-gated register file
// Lets writes and reads reach the array only while it is reported powered
// Marks read data one cycle after an accepted read and pulses an error
// flag for every access that had to be dropped

`timescale 1ns/1ns
`default_nettype none

module mem_access_guard (
     input  logic                  wclk
    ,input  logic                  rclk
    ,input  logic                  arst_n
    ,input  logic                  pwr_on
    ,input  logic                  req_we
    ,input  logic                  req_re
    ,output logic                  mem_we
    ,output logic                  mem_re
    ,input  mem_cfg_pkg::rf_data_t mem_rdata
    ,output mem_cfg_pkg::rf_data_t rdata
    ,output logic                  rd_valid
    ,output logic                  access_err
);

    // Power state seen in the write domain
    logic [1:0] pwr_on_w_q;
    logic       wr_ok;
    logic       wr_rej;
    logic       rd_rej;

    // --------------------
    // Write domain

    // Resets high to match the controller, which leaves reset powered
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_on_w_q <= 2'b11;
        end else begin
            pwr_on_w_q <= {pwr_on_w_q[0], pwr_on};
        end
    end

    // The synchronized copy delays write acceptance after wake, while the
    // direct level stops writes as soon as power is reported gone
    assign wr_ok  = pwr_on & pwr_on_w_q[1];
    assign mem_we = req_we & wr_ok;
    assign wr_rej = req_we & ~wr_ok;

    // --------------------
    // Read domain

    assign mem_re = req_re & pwr_on;
    assign rd_rej = req_re & ~pwr_on;

    // Read data comes from the array register, valid follows the accepted read
    assign rdata = mem_rdata;

    // Both rejection sources share one error pulse
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid   <= 1'b0;
            access_err <= 1'b0;
        end else begin
            rd_valid   <= mem_re;
            access_err <= wr_rej | rd_rej;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_cfg_pkg.sv */
// Register file configuration types
// Address and data types used on every port that carries an entry
// index or a stored word

`default_nettype none

`include "mem_defines.svh"

package mem_cfg_pkg;

    // One entry index into the array
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

    // One stored word as written and read back
    typedef logic [`RF_DATA_W-1:0] rf_data_t;

endpackage

`default_nettype wire

/* verilog/mem_defines.svh */
// Register file geometry and power timing
// Shared by the configuration package and the storage array so that
// the 8 x 177 layout and the acknowledge delay live in one place

`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// --------------------
// Array geometry

// Number of entries and the index width that covers them
`define RF_DEPTH    8
`define RF_ADDR_W   3

// Stored word width, six 32-bit words minus the spare parity slot
`define RF_DATA_W   177

// --------------------
// Power switch model

// Read-clock cycles from a change of power enable to the matching acknowledge
`define PWR_ACK_DLY 4

`endif

/* verilog/mem_pg_subsys.sv */
// Power-gated register file subsystem
// Ties the power sequencer, the access guard and the memory wrapper together
// External requests pass the guard before reaching the array

`timescale 1ns/1ns
`default_nettype none

module mem_pg_subsys (
     input  logic                  wclk
    ,input  logic                  rclk
    ,input  logic                  arst_n

    ,input  logic                  we
    ,input  mem_cfg_pkg::rf_addr_t waddr
    ,input  mem_cfg_pkg::rf_data_t wdata

    ,input  logic                  re
    ,input  mem_cfg_pkg::rf_addr_t raddr

    ,input  pwr_pkg::pwr_cmd_e     pwr_cmd

    ,input  logic                  fscan_rstbypen
    ,input  logic                  fscan_byprst_b

    ,output mem_cfg_pkg::rf_data_t rdata
    ,output logic                  rd_valid
    ,output logic                  access_err
    ,output logic                  pwr_on
    ,output logic                  pwr_busy
);

    import mem_cfg_pkg::*;

    // Power pins between the sequencer and the array
    logic     pgcb_isol_en;
    logic     pwr_enable_b_in;
    logic     pwr_enable_b_out;

    // Gated strobes and raw read data between the guard and the wrapper
    logic     mem_we;
    logic     mem_re;
    rf_data_t mem_rdata;

    pwr_gate_ctrl u_pwr_ctrl (
         .rclk             (rclk)
        ,.arst_n           (arst_n)
        ,.pwr_cmd          (pwr_cmd)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_on           (pwr_on)
        ,.pwr_busy         (pwr_busy)
    );

    mem_access_guard u_guard (
         .wclk       (wclk)
        ,.rclk       (rclk)
        ,.arst_n     (arst_n)
        ,.pwr_on     (pwr_on)
        ,.req_we     (we)
        ,.req_re     (re)
        ,.mem_we     (mem_we)
        ,.mem_re     (mem_re)
        ,.mem_rdata  (mem_rdata)
        ,.rdata      (rdata)
        ,.rd_valid   (rd_valid)
        ,.access_err (access_err)
    );

    // Address and write data go straight to the wrapper
    rf_pg_8x177 u_rf (
         .wclk             (wclk)
        ,.we               (mem_we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.re               (mem_re)
        ,.raddr            (raddr)
        ,.rdata            (mem_rdata)
        ,.arst_n           (arst_n)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
    );

endmodule

`default_nettype wire

/* verilog/mem_reset_sync.sv */
// Reset synchronizer for the memory IP reset
// Asserts asynchronously and releases through two flops on the read clock
// In scan bypass mode the reset is taken straight from the scan pin

`timescale 1ns/1ns
`default_nettype none

module mem_reset_sync (
     input  logic rclk
    ,input  logic arst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // Two-stage release chain
    logic [1:0] sync_q;

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // Scan mode hands reset control to the tester
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

`default_nettype wire

/* verilog/pwr_gate_ctrl.sv */
// Power gating sequencer for the register file
// On sleep it raises isolation, then opens the power switch and waits
// for the acknowledge. On wake it closes the switch, waits for the
// acknowledge and only then releases isolation
// All outputs come straight from flops

`timescale 1ns/1ns
`default_nettype none

module pwr_gate_ctrl (
     input  logic              rclk
    ,input  logic              arst_n
    ,input  pwr_pkg::pwr_cmd_e pwr_cmd
    ,input  logic              pwr_enable_b_out
    ,output logic              pgcb_isol_en
    ,output logic              pwr_enable_b_in
    ,output logic              pwr_on
    ,output logic              pwr_busy
);

    import pwr_pkg::*;

    pwr_state_e state_q;
    pwr_state_e state_d;

    // --------------------
    // Next state

    // Commands are only looked at in the two resting states
    always_comb begin
        state_d = state_q;
        case (state_q)
            PWR_ON: begin
                if (pwr_cmd == PWR_CMD_SLEEP) begin
                    state_d = PWR_ISOLATE;
                end
            end
            // One cycle with outputs clamped before the supply goes away
            PWR_ISOLATE: begin
                state_d = PWR_DOWN_WAIT;
            end
            PWR_DOWN_WAIT: begin
                if (pwr_enable_b_out) begin
                    state_d = PWR_OFF;
                end
            end
            PWR_OFF: begin
                if (pwr_cmd == PWR_CMD_WAKE) begin
                    state_d = PWR_UP_WAIT;
                end
            end
            // Hold isolation until the supply is reported stable
            PWR_UP_WAIT: begin
                if (!pwr_enable_b_out) begin
                    state_d = PWR_RELEASE;
                end
            end
            PWR_RELEASE: begin
                state_d = PWR_ON;
            end
            default: begin
                state_d = PWR_ON;
            end
        endcase
    end

    // --------------------
    // State and outputs

    // Outputs are decoded from the next state so they change together with it
    // pwr_on stays high through the sleep sequence and falls once the switch is
    // confirmed open, so each edge of it marks a finished sequence
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q         <= PWR_ON;
            pgcb_isol_en    <= 1'b0;
            pwr_enable_b_in <= 1'b0;
            pwr_on          <= 1'b1;
            pwr_busy        <= 1'b0;
        end else begin
            state_q         <= state_d;
            pgcb_isol_en    <= (state_d != PWR_ON) && (state_d != PWR_RELEASE);
            pwr_enable_b_in <= (state_d == PWR_DOWN_WAIT) || (state_d == PWR_OFF);
            pwr_on          <= (state_d == PWR_ON) || (state_d == PWR_ISOLATE) ||
                               (state_d == PWR_DOWN_WAIT);
            pwr_busy        <= (state_d != PWR_ON) && (state_d != PWR_OFF);
        end
    end

endmodule

`default_nettype wire

/* verilog/pwr_pkg.sv */
// Power controller types
// State encoding of the sleep and wake sequencer and the command
// opcode that requests a transition

`default_nettype none

package pwr_pkg;

    // Sequencer states, sleep path runs top to bottom and wake path continues from OFF
    typedef enum logic [2:0] {
        PWR_ON        = 3'd0,
        PWR_ISOLATE   = 3'd1,
        PWR_DOWN_WAIT = 3'd2,
        PWR_OFF       = 3'd3,
        PWR_UP_WAIT   = 3'd4,
        PWR_RELEASE   = 3'd5
    } pwr_state_e;

    // Command opcode presented by the system power manager
    typedef enum logic [1:0] {
        PWR_CMD_NONE  = 2'd0,
        PWR_CMD_SLEEP = 2'd1,
        PWR_CMD_WAKE  = 2'd2
    } pwr_cmd_e;

endpackage

`default_nettype wire

/* verilog/rf_array_8x177.sv */
// Behavioural two-clock register file array, 8 entries of 177 bits
// Writes on the write clock and registers reads on the read clock
// Models the power switch of the real macro with a delayed acknowledge,
// loss of contents while power is off and output clamping under isolation

`timescale 1ns/1ns
`default_nettype none

`include "mem_defines.svh"

module rf_array_8x177 (
     input  logic                  wclk
    ,input  logic                  we
    ,input  mem_cfg_pkg::rf_addr_t waddr
    ,input  mem_cfg_pkg::rf_data_t wdata

    ,input  logic                  rclk
    ,input  logic                  ip_reset_b
    ,input  logic                  re
    ,input  mem_cfg_pkg::rf_addr_t raddr
    ,output mem_cfg_pkg::rf_data_t rdata

    ,input  logic                  isol_en
    ,input  logic                  pwr_enable_b_in
    ,output logic                  pwr_enable_b_out
);

    import mem_cfg_pkg::*;

    // Storage cells
    rf_data_t mem_q [`RF_DEPTH];

    // Read register, holds the last word read until the next read
    rf_data_t rd_q;

    // Power switch settling chain
    logic [`PWR_ACK_DLY-1:0] ack_sr_q;

    // --------------------
    // Write side

    // Contents are lost once the switch opens, so every entry is zeroed
    // on each write clock while power is off or the IP is held in reset
    // Writes arriving in that window have nowhere to go and are dropped
    always_ff @(posedge wclk) begin
        if (!ip_reset_b || pwr_enable_b_in) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we) begin
            mem_q[waddr] <= wdata;
        end
    end

    // --------------------
    // Read side

    always_ff @(posedge rclk) begin
        if (re) begin
            rd_q <= mem_q[raddr];
        end
    end

    // Isolation clamps the outputs to a known level while the array may be unpowered
    assign rdata = isol_en ? '0 : rd_q;

    // --------------------
    // Power acknowledge

    // The enable ripples through the chain and the last stage reports that
    // the supply has actually reached the requested state
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            ack_sr_q <= '0;
        end else begin
            ack_sr_q <= {ack_sr_q[`PWR_ACK_DLY-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = ack_sr_q[`PWR_ACK_DLY-1];

endmodule

`default_nettype wire

/* verilog/rf_pg_8x177.sv */
// Power-gated 8 x 177 register file wrapper
// Brings the IP reset into the read clock domain and maps the power
// gating pins onto the storage array
// Presents a plain write port, read port and power interface upward

`timescale 1ns/1ns
`default_nettype none

module rf_pg_8x177 (
     input  logic                  wclk
    ,input  logic                  we
    ,input  mem_cfg_pkg::rf_addr_t waddr
    ,input  mem_cfg_pkg::rf_data_t wdata

    ,input  logic                  rclk
    ,input  logic                  re
    ,input  mem_cfg_pkg::rf_addr_t raddr
    ,output mem_cfg_pkg::rf_data_t rdata

    // Power interface from the gating controller
    ,input  logic                  arst_n
    ,input  logic                  pgcb_isol_en
    ,input  logic                  pwr_enable_b_in
    ,output logic                  pwr_enable_b_out

    // Scan reset control
    ,input  logic                  fscan_rstbypen
    ,input  logic                  fscan_byprst_b
);

    // IP reset after synchronization to the read clock
    logic ip_reset_b_sync;

    mem_reset_sync u_ip_reset_sync (
         .rclk           (rclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (ip_reset_b_sync)
    );

    // --------------------
    // Storage array

    // The behavioural array has a single power domain, so one enable
    // pin covers what the macro splits into several switch groups
    rf_array_8x177 u_array (
         .wclk             (wclk)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.rclk             (rclk)
        ,.ip_reset_b       (ip_reset_b_sync)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.isol_en          (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

`default_nettype wire
